//--- source/ecc_pkg.sv
`default_nettype none

package ecc_pkg;

    // Word geometry
    localparam int data_width   = 35;
    localparam int parity_width = 7;
    localparam int mem_depth    = 64;

    typedef logic [data_width-1:0]   ecc_data_t;
    typedef logic [parity_width-1:0] ecc_parity_t;
    typedef logic [parity_width-1:0] ecc_syndrome_t;

    // Bit 7 selects the register space, bits 5..0 index memory
    typedef logic [7:0]  wb_addr_t;
    typedef logic [5:0]  mem_index_t;
    typedef logic [15:0] err_count_t;

    // Register offsets
    localparam logic [2:0] reg_control       = 3'd0;
    localparam logic [2:0] reg_inject_data   = 3'd1;
    localparam logic [2:0] reg_inject_parity = 3'd2;
    localparam logic [2:0] reg_sbit_count    = 3'd3;
    localparam logic [2:0] reg_dbit_count    = 3'd4;
    localparam logic [2:0] reg_last_err_addr = 3'd5;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_respond
    } wb_state_t;

endpackage

`default_nettype wire

//--- source/ecc_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_encoder import ecc_pkg::*; (
    input  ecc_data_t   data,
    output ecc_parity_t parity
);

    // Hamming check bits
    assign parity[0] = data[0] ^ data[1] ^ data[3] ^ data[4] ^ data[6] ^ data[8]
                     ^ data[10] ^ data[11] ^ data[13] ^ data[15] ^ data[17]
                     ^ data[19] ^ data[21] ^ data[23] ^ data[25] ^ data[26]
                     ^ data[28] ^ data[30] ^ data[32] ^ data[34];

    assign parity[1] = data[0] ^ data[2] ^ data[3] ^ data[5] ^ data[6] ^ data[9]
                     ^ data[10] ^ data[12] ^ data[13] ^ data[16] ^ data[17]
                     ^ data[20] ^ data[21] ^ data[24] ^ data[25] ^ data[27]
                     ^ data[28] ^ data[31] ^ data[32];

    assign parity[2] = data[1] ^ data[2] ^ data[3] ^ data[7] ^ data[8] ^ data[9]
                     ^ data[10] ^ data[14] ^ data[15] ^ data[16] ^ data[17]
                     ^ data[22] ^ data[23] ^ data[24] ^ data[25] ^ data[29]
                     ^ data[30] ^ data[31] ^ data[32];

    assign parity[3] = (^data[10:4]) ^ (^data[25:18]) ^ data[33] ^ data[34];

    assign parity[4] = ^data[25:11];

    assign parity[5] = ^data[34:26];

    // Overall bit over a fixed subset
    assign parity[6] = data[0] ^ data[1] ^ data[2] ^ data[4] ^ data[5] ^ data[7]
                     ^ data[10] ^ data[11] ^ data[12] ^ data[14] ^ data[17]
                     ^ data[18] ^ data[21] ^ data[23] ^ data[24] ^ data[26]
                     ^ data[27] ^ data[29] ^ data[32] ^ data[33];

endmodule

`default_nettype wire

//--- source/ecc_corrector.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_corrector import ecc_pkg::*; (
    input  ecc_data_t   data_in,
    input  ecc_parity_t parity_in,
    input  logic        bypass,
    output ecc_data_t   data_out,
    output logic        sbit_err,
    output logic        dbit_err
);

    ecc_parity_t   check_parity;
    ecc_syndrome_t syndrome;
    logic [5:0]    flip_index;
    ecc_data_t     mask;
    logic          data_hit;
    logic          check_hit;
    logic          single_err;
    logic          double_err;

    ecc_encoder check_encoder_inst (
        .data   (data_in),
        .parity (check_parity)
    );

    assign syndrome = parity_in ^ check_parity;

    // Flipped data bit for each data-bit syndrome
    always_comb begin
        flip_index = '1;
        case (syndrome)
            7'b1000011: flip_index = 6'd0;
            7'b1000101: flip_index = 6'd1;
            7'b1000110: flip_index = 6'd2;
            7'b0000111: flip_index = 6'd3;
            7'b1001001: flip_index = 6'd4;
            7'b1001010: flip_index = 6'd5;
            7'b0001011: flip_index = 6'd6;
            7'b1001100: flip_index = 6'd7;
            7'b0001101: flip_index = 6'd8;
            7'b0001110: flip_index = 6'd9;
            7'b1001111: flip_index = 6'd10;
            7'b1010001: flip_index = 6'd11;
            7'b1010010: flip_index = 6'd12;
            7'b0010011: flip_index = 6'd13;
            7'b1010100: flip_index = 6'd14;
            7'b0010101: flip_index = 6'd15;
            7'b0010110: flip_index = 6'd16;
            7'b1010111: flip_index = 6'd17;
            7'b1011000: flip_index = 6'd18;
            7'b0011001: flip_index = 6'd19;
            7'b0011010: flip_index = 6'd20;
            7'b1011011: flip_index = 6'd21;
            7'b0011100: flip_index = 6'd22;
            7'b1011101: flip_index = 6'd23;
            7'b1011110: flip_index = 6'd24;
            7'b0011111: flip_index = 6'd25;
            7'b1100001: flip_index = 6'd26;
            7'b1100010: flip_index = 6'd27;
            7'b0100011: flip_index = 6'd28;
            7'b1100100: flip_index = 6'd29;
            7'b0100101: flip_index = 6'd30;
            7'b0100110: flip_index = 6'd31;
            7'b1100111: flip_index = 6'd32;
            7'b1101000: flip_index = 6'd33;
            7'b0101001: flip_index = 6'd34;
            default:    flip_index = '1;
        endcase
    end

    // Index 63 shifts out entirely, leaving an empty mask
    assign mask      = ecc_data_t'(1'b1) << flip_index;
    assign data_hit  = |mask;
    // A lone check bit flipped
    assign check_hit = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);

    assign single_err = data_hit || check_hit;
    assign double_err = (syndrome != '0) && !single_err;

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = !bypass && single_err;
    assign dbit_err = !bypass && double_err;

    // Data-bit columns are odd weight and never alias a check bit
    always_comb begin
        assert final (!(data_hit && check_hit));
        assert final (!data_hit || (^syndrome));
    end

endmodule

`default_nettype wire

//--- source/wb_request_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wb_request_decoder import ecc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  wb_addr_t   adr,
    input  ecc_data_t  dat_w,
    output logic       ack,
    output logic       mem_write,
    output logic       mem_read,
    output mem_index_t mem_index,
    output logic       reg_write,
    output logic [2:0] reg_offset,
    output ecc_data_t  wr_data,
    output logic       read_done,
    output logic       reg_select
);

    wb_state_t state;
    wb_addr_t  adr_q;
    ecc_data_t dat_q;
    logic      we_q;
    logic      accept;

    assign accept = (state == st_idle) && cyc && stb;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (cyc && stb) begin
                        state <= st_access;
                    end
                end
                st_access:  state <= st_respond;
                st_respond: state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // Request captured on acceptance and held through respond
    always_ff @(posedge clk) begin
        if (accept) begin
            adr_q <= adr;
            dat_q <= dat_w;
            we_q  <= we;
        end
    end

    assign reg_select = adr_q[7];
    assign mem_index  = adr_q[5:0];
    assign reg_offset = adr_q[2:0];
    assign wr_data    = dat_q;

    // One strobe in the access cycle
    assign mem_write = (state == st_access) && we_q && !reg_select;
    assign mem_read  = (state == st_access) && !we_q && !reg_select;
    assign reg_write = (state == st_access) && we_q && reg_select;

    assign ack       = (state == st_respond);
    assign read_done = (state == st_respond) && !we_q && !reg_select;

    ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        ack |-> (cyc && stb));

endmodule

`default_nettype wire

//--- source/ecc_memory_bank.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_memory_bank import ecc_pkg::*; (
    input  logic        clk,
    input  logic        mem_write,
    input  logic        mem_read,
    input  mem_index_t  mem_index,
    input  ecc_data_t   wr_data,
    input  ecc_data_t   inject_data,
    input  ecc_parity_t inject_parity,
    output ecc_data_t   rd_data,
    output ecc_parity_t rd_parity
);

    // Codeword layout is {parity, data}
    typedef logic [data_width+parity_width-1:0] codeword_t;

    codeword_t   mem [mem_depth];
    ecc_parity_t wr_parity;
    codeword_t   wr_codeword;
    codeword_t   rd_codeword;

    ecc_encoder write_encoder_inst (
        .data   (wr_data),
        .parity (wr_parity)
    );

    // Fault masks applied on the way into storage
    assign wr_codeword = {wr_parity ^ inject_parity, wr_data ^ inject_data};

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[mem_index] <= wr_codeword;
        end
    end

    // Read port output register, held until the next read
    always_ff @(posedge clk) begin
        if (mem_read) begin
            rd_codeword <= mem[mem_index];
        end
    end

    assign rd_data   = rd_codeword[data_width-1:0];
    assign rd_parity = rd_codeword[data_width+parity_width-1:data_width];

    no_read_write_overlap: assert property (@(posedge clk)
        !(mem_write && mem_read));

    // Read data lands one cycle after the strobe, in the respond cycle
    read_data_stable: assert property (@(posedge clk)
        mem_read |=> ##1 $stable(rd_codeword));

endmodule

`default_nettype wire

//--- source/ecc_status_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_status_regs import ecc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        reg_write,
    input  logic [2:0]  reg_offset,
    input  ecc_data_t   wr_data,
    input  logic        reg_select,
    input  logic        read_done,
    input  mem_index_t  mem_index,
    input  ecc_data_t   corrected,
    input  logic        sbit_err,
    input  logic        dbit_err,
    output logic        bypass,
    output ecc_data_t   inject_data,
    output ecc_parity_t inject_parity,
    output ecc_data_t   dat_r,
    output logic        sbit_pulse,
    output logic        dbit_pulse
);

    err_count_t sbit_count;
    err_count_t dbit_count;
    mem_index_t last_err_addr;
    ecc_data_t  reg_rdata;

    // Flags only count on a finished memory read
    assign sbit_pulse = read_done && sbit_err;
    assign dbit_pulse = read_done && dbit_err;

    always_ff @(posedge clk) begin
        if (reset) begin
            bypass        <= 1'b0;
            inject_data   <= '0;
            inject_parity <= '0;
            sbit_count    <= '0;
            dbit_count    <= '0;
            last_err_addr <= '0;
        end else begin
            if (reg_write) begin
                case (reg_offset)
                    reg_control:       bypass        <= wr_data[0];
                    reg_inject_data:   inject_data   <= wr_data;
                    reg_inject_parity: inject_parity <= wr_data[parity_width-1:0];
                    default:           ;
                endcase
            end
            // Saturate at all ones
            if (sbit_pulse && (sbit_count != '1)) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (dbit_pulse && (dbit_count != '1)) begin
                dbit_count <= dbit_count + 1'b1;
            end
            if (sbit_pulse || dbit_pulse) begin
                last_err_addr <= mem_index;
            end
        end
    end

    always_comb begin
        case (reg_offset)
            reg_control:       reg_rdata = ecc_data_t'(bypass);
            reg_inject_data:   reg_rdata = inject_data;
            reg_inject_parity: reg_rdata = ecc_data_t'(inject_parity);
            reg_sbit_count:    reg_rdata = ecc_data_t'(sbit_count);
            reg_dbit_count:    reg_rdata = ecc_data_t'(dbit_count);
            reg_last_err_addr: reg_rdata = ecc_data_t'(last_err_addr);
            default:           reg_rdata = '0;
        endcase
    end

    assign dat_r = reg_select ? reg_rdata : corrected;

    // Corrector silences its flags in bypass
    flags_off_in_bypass: assert property (@(posedge clk) disable iff (reset)
        (sbit_err || dbit_err) |-> !bypass);

endmodule

`default_nettype wire

//--- source/ecc_memory_top.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_memory_top import ecc_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  wb_addr_t  adr,
    input  ecc_data_t dat_w,
    output ecc_data_t dat_r,
    output logic      ack,
    output logic      sbit_err,
    output logic      dbit_err
);

    logic        mem_write;
    logic        mem_read;
    mem_index_t  mem_index;
    logic        reg_write;
    logic [2:0]  reg_offset;
    ecc_data_t   wr_data;
    logic        read_done;
    logic        reg_select;
    ecc_data_t   rd_data;
    ecc_parity_t rd_parity;
    ecc_data_t   corrected;
    logic        corr_sbit;
    logic        corr_dbit;
    logic        bypass;
    ecc_data_t   inject_data;
    ecc_parity_t inject_parity;

    wb_request_decoder wb_request_decoder_inst (
        .clk        (clk),
        .reset      (reset),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .ack        (ack),
        .mem_write  (mem_write),
        .mem_read   (mem_read),
        .mem_index  (mem_index),
        .reg_write  (reg_write),
        .reg_offset (reg_offset),
        .wr_data    (wr_data),
        .read_done  (read_done),
        .reg_select (reg_select)
    );

    ecc_memory_bank ecc_memory_bank_inst (
        .clk           (clk),
        .mem_write     (mem_write),
        .mem_read      (mem_read),
        .mem_index     (mem_index),
        .wr_data       (wr_data),
        .inject_data   (inject_data),
        .inject_parity (inject_parity),
        .rd_data       (rd_data),
        .rd_parity     (rd_parity)
    );

    ecc_corrector ecc_corrector_inst (
        .data_in   (rd_data),
        .parity_in (rd_parity),
        .bypass    (bypass),
        .data_out  (corrected),
        .sbit_err  (corr_sbit),
        .dbit_err  (corr_dbit)
    );

    ecc_status_regs ecc_status_regs_inst (
        .clk           (clk),
        .reset         (reset),
        .reg_write     (reg_write),
        .reg_offset    (reg_offset),
        .wr_data       (wr_data),
        .reg_select    (reg_select),
        .read_done     (read_done),
        .mem_index     (mem_index),
        .corrected     (corrected),
        .sbit_err      (corr_sbit),
        .dbit_err      (corr_dbit),
        .bypass        (bypass),
        .inject_data   (inject_data),
        .inject_parity (inject_parity),
        .dat_r         (dat_r),
        .sbit_pulse    (sbit_err),
        .dbit_pulse    (dbit_err)
    );

endmodule

`default_nettype wire

//--- verification/ecc_memory_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_memory_tb import ecc_pkg::*; ();

    localparam int clk_period   = 4;
    localparam int drive_delay  = 1;
    localparam int reset_cycles = 8;
    localparam int ack_latency  = 2;
    localparam int max_rows     = 64;

    localparam logic [1:0] op_mem_write = 2'd0;
    localparam logic [1:0] op_mem_read  = 2'd1;
    localparam logic [1:0] op_reg_write = 2'd2;
    localparam logic [1:0] op_reg_read  = 2'd3;
    localparam wb_addr_t   reg_base     = 8'h80;

    logic      clk;
    logic      reset;
    logic      cyc;
    logic      stb;
    logic      we;
    wb_addr_t  adr;
    ecc_data_t dat_w;
    ecc_data_t dat_r;
    logic      ack;
    logic      sbit_err;
    logic      dbit_err;

    // Stimulus and expected values, one row per bus access
    logic [1:0] row_op    [max_rows];
    wb_addr_t   row_adr   [max_rows];
    ecc_data_t  row_wdata [max_rows];
    ecc_data_t  row_exp   [max_rows];
    logic       row_sbit  [max_rows];
    logic       row_dbit  [max_rows];
    int         num_rows = 0;

    // Model of the status registers while the table is built
    int          exp_sbit_count = 0;
    int          exp_dbit_count = 0;
    mem_index_t  exp_last_err   = '0;
    logic [31:0] lcg_state      = 32'h9518;

    int error_count   = 0;
    int failed_tests  = 0;
    int cycle_count   = 0;
    int timeout_limit = 0;

    ecc_memory_top ecc_memory_top_inst (
        .clk      (clk),
        .reset    (reset),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .dat_r    (dat_r),
        .ack      (ack),
        .sbit_err (sbit_err),
        .dbit_err (dbit_err)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            $display("Timeout: no acknowledge after %0d cycles, run stopped", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function ecc_data_t random_word();
        logic [2:0] upper;
        lcg_state = lcg_step(lcg_state);
        upper = lcg_state[31:29];
        lcg_state = lcg_step(lcg_state);
        return {upper, lcg_state};
    endfunction

    function automatic string op_name(input logic [1:0] op);
        case (op)
            op_mem_write: return "mem write";
            op_mem_read:  return "mem read ";
            op_reg_write: return "reg write";
            default:      return "reg read ";
        endcase
    endfunction

    task add_row(input logic [1:0] op, input wb_addr_t address, input ecc_data_t wdata,
                 input ecc_data_t exp, input logic sbit, input logic dbit);
        row_op[num_rows]    = op;
        row_adr[num_rows]   = address;
        row_wdata[num_rows] = wdata;
        row_exp[num_rows]   = exp;
        row_sbit[num_rows]  = sbit;
        row_dbit[num_rows]  = dbit;
        num_rows++;
    endtask

    task mem_write_row(input mem_index_t idx, input ecc_data_t data);
        add_row(op_mem_write, wb_addr_t'(idx), data, '0, 1'b0, 1'b0);
    endtask

    // Flagged reads also advance the expected counters
    task mem_read_row(input mem_index_t idx, input ecc_data_t exp, input logic sbit,
                      input logic dbit);
        add_row(op_mem_read, wb_addr_t'(idx), '0, exp, sbit, dbit);
        if (sbit || dbit) begin
            exp_last_err = idx;
        end
        if (sbit) begin
            exp_sbit_count++;
        end
        if (dbit) begin
            exp_dbit_count++;
        end
    endtask

    task reg_write_row(input logic [2:0] offset, input ecc_data_t data);
        add_row(op_reg_write, reg_base | offset, data, '0, 1'b0, 1'b0);
    endtask

    task reg_read_row(input logic [2:0] offset, input ecc_data_t exp);
        add_row(op_reg_read, reg_base | offset, '0, exp, 1'b0, 1'b0);
    endtask

    task store_with_data_fault(input mem_index_t idx, input ecc_data_t data,
                               input ecc_data_t mask);
        reg_write_row(reg_inject_data, mask);
        mem_write_row(idx, data);
        reg_write_row(reg_inject_data, '0);
    endtask

    task build_table();
        ecc_data_t words [8];
        int        bits [3];
        bits = '{0, 17, 34};
        for (int i = 0; i < 8; i++) begin
            words[i] = random_word();
        end
        // Clean write and read back
        mem_write_row(6'd3, words[0]);
        mem_write_row(6'd10, words[1]);
        mem_read_row(6'd3, words[0], 1'b0, 1'b0);
        mem_read_row(6'd10, words[1], 1'b0, 1'b0);
        // Single data bit faults are corrected
        for (int k = 0; k < 3; k++) begin
            store_with_data_fault(mem_index_t'(20 + k), words[2 + k], ecc_data_t'(1) << bits[k]);
            mem_read_row(mem_index_t'(20 + k), words[2 + k], 1'b1, 1'b0);
        end
        reg_read_row(reg_sbit_count, ecc_data_t'(exp_sbit_count));
        // Single check bit fault
        reg_write_row(reg_inject_parity, ecc_data_t'(7'h10));
        mem_write_row(6'd30, words[5]);
        reg_write_row(reg_inject_parity, '0);
        mem_read_row(6'd30, words[5], 1'b1, 1'b0);
        reg_read_row(reg_sbit_count, ecc_data_t'(exp_sbit_count));
        // Two flipped data bits
        store_with_data_fault(6'd40, words[6], ecc_data_t'(3));
        mem_read_row(6'd40, words[6] ^ ecc_data_t'(3), 1'b0, 1'b1);
        reg_read_row(reg_dbit_count, ecc_data_t'(exp_dbit_count));
        reg_read_row(reg_last_err_addr, ecc_data_t'(exp_last_err));
        // Bypass returns raw words and leaves the counters alone
        reg_write_row(reg_control, ecc_data_t'(1));
        mem_read_row(6'd40, words[6] ^ ecc_data_t'(3), 1'b0, 1'b0);
        mem_read_row(6'd20, words[2] ^ ecc_data_t'(1), 1'b0, 1'b0);
        reg_read_row(reg_sbit_count, ecc_data_t'(exp_sbit_count));
        reg_read_row(reg_dbit_count, ecc_data_t'(exp_dbit_count));
        reg_write_row(reg_control, '0);
        mem_read_row(6'd20, words[2], 1'b1, 1'b0);
        reg_read_row(reg_sbit_count, ecc_data_t'(exp_sbit_count));
        reg_read_row(reg_last_err_addr, ecc_data_t'(exp_last_err));
        // Register readback and unmapped offsets
        reg_write_row(reg_control, ecc_data_t'(1));
        reg_read_row(reg_control, ecc_data_t'(1));
        reg_write_row(reg_control, '0);
        reg_write_row(reg_inject_data, words[7]);
        reg_read_row(reg_inject_data, words[7]);
        reg_write_row(reg_inject_data, '0);
        reg_write_row(reg_inject_parity, ecc_data_t'(7'h55));
        reg_read_row(reg_inject_parity, ecc_data_t'(7'h55));
        reg_write_row(reg_inject_parity, '0);
        reg_read_row(3'd6, '0);
        reg_read_row(3'd7, '0);
    endtask

    // Called just after a drive point; returns at the next drive point
    task automatic bus_access(input logic write, input wb_addr_t address,
                              input ecc_data_t data, output ecc_data_t rdata,
                              output logic sbit, output logic dbit, output int edges);
        edges = 0;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = address;
        dat_w = data;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!ack);
        rdata = dat_r;
        sbit  = sbit_err;
        dbit  = dbit_err;
        @(posedge clk);
        #drive_delay;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t address, input ecc_data_t data,
                            output logic sbit, output logic dbit, output int edges);
        ecc_data_t unused;
        bus_access(1'b1, address, data, unused, sbit, dbit, edges);
    endtask

    task automatic wb_read(input wb_addr_t address, output ecc_data_t rdata,
                           output logic sbit, output logic dbit, output int edges);
        bus_access(1'b0, address, '0, rdata, sbit, dbit, edges);
    endtask

    task automatic check_row(input int i, input ecc_data_t rdata, input logic sbit,
                             input logic dbit, input int edges);
        int errors_before;
        errors_before = error_count;
        assert (edges == ack_latency) else begin
            $display("[ERROR] %0t: row %0d ack after %0d cycles, expected %0d",
                     $time, i, edges, ack_latency);
            error_count++;
        end
        if (row_op[i] == op_mem_read || row_op[i] == op_reg_read) begin
            assert (rdata === row_exp[i]) else begin
                $display("[ERROR] %0t: row %0d read %h, expected %h",
                         $time, i, rdata, row_exp[i]);
                error_count++;
            end
        end
        assert (sbit === row_sbit[i] && dbit === row_dbit[i]) else begin
            $display("[ERROR] %0t: row %0d flags sbit=%b dbit=%b, expected sbit=%b dbit=%b",
                     $time, i, sbit, dbit, row_sbit[i], row_dbit[i]);
            error_count++;
        end
        if (error_count != errors_before) begin
            failed_tests++;
        end
        $display("Test %0d %s adr=%02h: %s", i, op_name(row_op[i]), row_adr[i],
                 (error_count == errors_before) ? "ok" : "FAIL");
    endtask

    initial begin
        ecc_data_t rdata;
        logic      sbit;
        logic      dbit;
        int        edges;
        clk   = 1'b0;
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        build_table();
        timeout_limit = num_rows * 8 + reset_cycles;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            rdata = '0;
            if (row_op[i] == op_mem_write || row_op[i] == op_reg_write) begin
                wb_write(row_adr[i], row_wdata[i], sbit, dbit, edges);
            end else begin
                wb_read(row_adr[i], rdata, sbit, dbit, edges);
            end
            check_row(i, rdata, sbit, dbit, edges);
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 num_rows, num_rows - failed_tests, failed_tests, error_count);
        if (failed_tests == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
source/ecc_pkg.sv
source/ecc_encoder.sv
source/ecc_corrector.sv
source/wb_request_decoder.sv
source/ecc_memory_bank.sv
source/ecc_status_regs.sv
source/ecc_memory_top.sv
verification/ecc_memory_tb.sv
